/* design/led_panel_top.sv */
`timescale 1ns/1ps
`default_nettype none

module led_panel_top (
	input  logic              clk,
	input  logic              rst,

	// APB host port
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  panel_pkg::paddr_t paddr,
	input  panel_pkg::word_t  pwdata,
	output logic              pready,
	output logic              pslverr,

	// panel pins
	output panel_pkg::row_t   row_addr,
	output panel_pkg::col_t   col_addr,
	output logic              display_clk,
	output logic              latch,
	output logic              display_oe,
	output panel_pkg::pixel_t dout_a,  // top half
	output panel_pkg::pixel_t dout_b   // bottom half
);

	logic fetch; // read strobe into the framebuffer

	// free-running scan, no back-pressure
	scan_sequencer i_scan_sequencer (
		.clk         (clk),
		.rst         (rst),
		.fetch       (fetch),
		.row_addr    (row_addr),
		.col_addr    (col_addr),
		.display_clk (display_clk),
		.latch       (latch),
		.display_oe  (display_oe)
	);

	// scan address is also what the framebuffer reads
	pixel_framebuffer i_pixel_framebuffer (
		.clk      (clk),
		.rst      (rst),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.fetch    (fetch),
		.row_addr (row_addr),
		.col_addr (col_addr),
		.dout_a   (dout_a),
		.dout_b   (dout_b)
	);

endmodule

`default_nettype wire

/* design/panel_pkg.sv */
`default_nettype none

package panel_pkg;

	// panel geometry
	localparam int COLUMNS = 64;
	localparam int ROWS    = 32; // row pairs scanned top and bottom together

	// blanking window after each latch
	localparam int DISPLAY_CYCLES = 3;

	// one pixel per APB word
	localparam int FB_WORDS   = 4096;
	localparam int HALF_WORDS = FB_WORDS / 2;
	localparam int FB_BYTES   = FB_WORDS * 4; // first APB address past the buffer

	// derived widths
	localparam int COL_W       = $clog2(COLUMNS);
	localparam int ROW_W       = $clog2(ROWS);
	localparam int PIXEL_W     = 4;
	localparam int FB_ADDR_W   = $clog2(FB_WORDS);
	localparam int BLANK_CNT_W = $clog2(DISPLAY_CYCLES + 1);

	// column and row addresses on the panel
	typedef logic [COL_W-1:0] col_t;
	typedef logic [ROW_W-1:0] row_t;

	// one 4-bit pixel
	typedef logic [PIXEL_W-1:0] pixel_t;

	// word index as {half, row, col}
	typedef logic [FB_ADDR_W-1:0] fb_addr_t;

	// index inside one half as {row, col}
	typedef logic [FB_ADDR_W-2:0] half_addr_t;

	// blanking counter
	typedef logic [BLANK_CNT_W-1:0] blank_cnt_t;

	// APB address and write data
	typedef logic [31:0] paddr_t;
	typedef logic [31:0] word_t;

endpackage

`default_nettype wire

/* design/pixel_framebuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_framebuffer (
	input  logic              clk,
	input  logic              rst,
	// APB slave, write only
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  panel_pkg::paddr_t paddr,
	input  panel_pkg::word_t  pwdata,
	output logic              pready,
	output logic              pslverr,
	// scan read port
	input  logic              fetch,
	input  panel_pkg::row_t   row_addr,
	input  panel_pkg::col_t   col_addr,
	output panel_pkg::pixel_t dout_a,
	output panel_pkg::pixel_t dout_b
);
	import panel_pkg::*;

	// one memory per panel half
	pixel_t mem_top [HALF_WORDS];
	pixel_t mem_bot [HALF_WORDS];

	logic       access;
	logic       in_range;
	logic       aligned;
	logic       wr_ok;
	fb_addr_t   wr_idx;
	logic       wr_bot;
	half_addr_t wr_off;
	pixel_t     wr_pixel;
	half_addr_t rd_off;

	// access phase of a transfer
	assign access   = psel && penable;
	assign in_range = (paddr < paddr_t'(FB_BYTES));
	assign aligned  = (paddr[1:0] == 2'b00);
	assign wr_ok    = access && pwrite && in_range && aligned;

	// no wait states
	assign pready = 1'b1;

	// reads, out of range and unaligned writes all error
	assign pslverr = access && !(pwrite && in_range && aligned);

	// byte address to word index
	assign wr_idx   = paddr[FB_ADDR_W+1:2];
	assign wr_bot   = wr_idx[FB_ADDR_W-1]; // top index bit picks the half
	assign wr_off   = wr_idx[FB_ADDR_W-2:0];
	assign wr_pixel = pwdata[PIXEL_W-1:0]; // upper data bits dropped

	// both halves share the scan row and column
	assign rd_off = {row_addr, col_addr};

	always_ff @(posedge clk) begin
		if (wr_ok && !wr_bot) begin
			mem_top[wr_off] <= wr_pixel;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok && wr_bot) begin
			mem_bot[wr_off] <= wr_pixel;
		end
	end

	// registered scan read, holds between fetches
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			dout_a <= '0;
			dout_b <= '0;
		end else if (fetch) begin
			dout_a <= mem_top[rd_off];
			dout_b <= mem_bot[rd_off];
		end
	end

endmodule

`default_nettype wire

/* design/scan_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_sequencer (
	input  logic            clk,
	input  logic            rst,
	output logic            fetch,
	output panel_pkg::row_t row_addr,
	output panel_pkg::col_t col_addr,
	output logic            display_clk,
	output logic            latch,
	output logic            display_oe
);
	import panel_pkg::*;

	// Each state loads the pin pattern shown in the following cycle, so
	// all panel strobes come straight from flops.
	typedef enum logic [2:0] {
		FETCH,
		SHIFT_HIGH,
		SHIFT_LOW,
		LATCH_HIGH,
		LATCH_LOW,
		BLANK
	} scan_state_t;

	scan_state_t state;
	scan_state_t state_next;
	blank_cnt_t  blank_cnt;
	logic        last_col;
	logic        last_row;
	logic        blank_done;

	assign last_col   = (col_addr == col_t'(COLUMNS - 1));
	assign last_row   = (row_addr == row_t'(ROWS - 1));
	assign blank_done = (blank_cnt == blank_cnt_t'(DISPLAY_CYCLES));

	always_comb begin
		state_next = state;
		case (state)
			FETCH: begin
				state_next = SHIFT_HIGH;
			end
			SHIFT_HIGH: begin
				state_next = SHIFT_LOW;
			end
			SHIFT_LOW: begin
				if (last_col) begin
					state_next = LATCH_HIGH; // row fully shifted in
				end else begin
					state_next = FETCH;
				end
			end
			LATCH_HIGH: begin
				state_next = LATCH_LOW;
			end
			LATCH_LOW: begin
				state_next = BLANK;
			end
			BLANK: begin
				if (blank_done) begin
					state_next = FETCH;
				end
			end
			default: begin
				state_next = FETCH;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= FETCH;
		end else begin
			state <= state_next;
		end
	end

	// panel strobes
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			fetch       <= 1'b0;
			display_clk <= 1'b0;
			latch       <= 1'b0;
			display_oe  <= 1'b1;
		end else begin
			fetch       <= (state == FETCH);
			display_clk <= (state == SHIFT_HIGH); // one cycle after the fetch
			latch       <= (state == LATCH_HIGH) || (state == LATCH_LOW);
			display_oe  <= !((state == BLANK) && !blank_done); // active low
		end
	end

	// column advances as display_clk falls
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			col_addr <= '0;
		end else if (state == SHIFT_LOW) begin
			if (last_col) begin
				col_addr <= '0;
			end else begin
				col_addr <= col_addr + 1'b1;
			end
		end
	end

	// row advances on the second latch cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			row_addr <= '0;
		end else if (state == LATCH_LOW) begin
			if (last_row) begin
				row_addr <= '0;
			end else begin
				row_addr <= row_addr + 1'b1;
			end
		end
	end

	// counts the lit window, first BLANK cycle still has latch high
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			blank_cnt <= '0;
		end else if ((state == BLANK) && !blank_done) begin
			blank_cnt <= blank_cnt + 1'b1;
		end else begin
			blank_cnt <= '0;
		end
	end

endmodule

`default_nettype wire

/* led_panel_top.f */
+incdir+include
design/panel_pkg.sv
design/pixel_framebuffer.sv
design/scan_sequencer.sv
design/led_panel_top.sv
tests/led_panel_checker.sv
tests/led_panel_tb.sv

/* tests/led_panel_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module led_panel_checker (
	input logic clk,
	input logic rst,
	input logic display_clk,
	input logic latch,
	input logic display_oe
);
	import panel_pkg::*;

	// column clock is a one-cycle pulse
	clk_single_pulse: assert property (@(posedge clk) disable iff (rst)
		display_clk |=> !display_clk)
		else $error("display_clk stayed high for more than one cycle");

	// no shifting while a row latches
	latch_excludes_shift: assert property (@(posedge clk) disable iff (rst)
		!(latch && display_clk))
		else $error("latch and display_clk high in the same cycle");

	// lit window opens as the latch pulse ends
	oe_after_latch: assert property (@(posedge clk) disable iff (rst)
		$fell(display_oe) |-> $fell(latch))
		else $error("display_oe went low without a preceding latch pulse");

	oe_window_length: assert property (@(posedge clk) disable iff (rst)
		$fell(display_oe) |-> (!display_oe) [*DISPLAY_CYCLES] ##1 display_oe)
		else $error("display_oe low run differs from the blanking count");

endmodule

bind led_panel_top led_panel_checker i_led_panel_checker (
	.clk         (clk),
	.rst         (rst),
	.display_clk (display_clk),
	.latch       (latch),
	.display_oe  (display_oe)
);

`default_nettype wire

/* include/panel_tb_vectors.svh */
`ifndef PANEL_TB_VECTORS_SVH
`define PANEL_TB_VECTORS_SVH

// one APB transfer and the pslverr it should return
typedef struct packed {
	panel_pkg::paddr_t addr;
	panel_pkg::word_t  data;
	logic              write;
	logic              err;
} apb_vec_t;

localparam int NUM_APB_VECS = 12;

localparam apb_vec_t APB_VECS [NUM_APB_VECS] = '{
	'{32'h0000_0000, 32'h0000_0009, 1'b1, 1'b0}, // first top pixel
	'{32'h0000_0004, 32'hffff_fff6, 1'b1, 1'b0}, // upper data bits ignored
	'{32'h0000_00fc, 32'h0000_0003, 1'b1, 1'b0}, // end of row 0
	'{32'h0000_1ffc, 32'h0000_000c, 1'b1, 1'b0}, // last top pixel
	'{32'h0000_2000, 32'h0000_0005, 1'b1, 1'b0}, // first bottom pixel
	'{32'h0000_3ffc, 32'h0000_000e, 1'b1, 1'b0}, // last bottom pixel
	'{32'h0000_0000, 32'h0000_0000, 1'b0, 1'b1}, // reads always error
	'{32'h0000_2000, 32'h0000_0000, 1'b0, 1'b1},
	'{32'h0000_4000, 32'h0000_0007, 1'b1, 1'b1}, // just past the buffer
	'{32'hffff_fffc, 32'h0000_0007, 1'b1, 1'b1},
	'{32'h0000_0006, 32'h0000_000f, 1'b1, 1'b1}, // unaligned
	'{32'h0000_2001, 32'h0000_000f, 1'b1, 1'b1}
};

`endif

/* tests/led_panel_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module led_panel_tb;
	import panel_pkg::*;

	`include "panel_tb_vectors.svh"

	localparam int HALF_PERIOD = 10;
	localparam int WAIT_LIMIT  = 1000; // clk cycles for about five scan rows

	logic   clk;
	logic   rst;
	logic   psel;
	logic   penable;
	logic   pwrite;
	paddr_t paddr;
	word_t  pwdata;
	logic   pready;
	logic   pslverr;
	row_t   row_addr;
	col_t   col_addr;
	logic   display_clk;
	logic   latch;
	logic   display_oe;
	pixel_t dout_a;
	pixel_t dout_b;

	pixel_t model [FB_WORDS];
	pixel_t model_old [FB_WORDS]; // value before the last write
	time    wr_time [FB_WORDS];   // edge that stored the last write
	logic   scan_check_en;

	led_panel_top i_led_panel_top (.*);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else
			stop_with_failure($sformatf("CHECK FAILED %s: got %h, expected %h",
				name, got, exp));
	endtask

	task automatic check_idle_outputs();
		check_value("display_clk", display_clk, 1'b0);
		check_value("latch", latch, 1'b0);
		check_value("display_oe", display_oe, 1'b1);
		check_value("row_addr", row_addr, 0);
		check_value("col_addr", col_addr, 0);
	endtask

	// setup, access, then idle again
	task automatic apb_transfer(input paddr_t addr, input word_t data, input logic is_write,
			input logic exp_err);
		int idx;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= is_write;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_value("pready", pready, 1'b1);
		check_value("pslverr", pslverr, exp_err);
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		if (is_write && !exp_err) begin
			idx            = int'(addr) / 4;
			model_old[idx] = model[idx];
			model[idx]     = data[3:0];
			wr_time[idx]   = $time;
		end
	endtask

	// a write on the fetch edge is not yet visible
	function automatic pixel_t expected_pixel(input int idx, input time fetch_edge);
		if (wr_time[idx] < fetch_edge) begin
			return model[idx];
		end else begin
			return model_old[idx];
		end
	endfunction

	task automatic wait_latch_rise();
		int   cycles;
		logic was_high;
		cycles = 0;
		@(negedge clk);
		was_high = 1'b1; // a pulse already running does not count
		while (!(latch && !was_high)) begin
			was_high = latch;
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				stop_with_failure("timeout while waiting for a latch pulse");
			end
		end
	endtask

	task automatic wait_shift_out(input row_t row, input col_t col);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!(display_clk && row_addr == row && col_addr == col)) begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				stop_with_failure("timeout while waiting for a pixel to be shifted out");
			end
		end
	endtask

	// scan monitor
	initial begin
		int   top_idx;
		int   pulses_in_row;
		logic col_known;
		logic row_started;
		logic latch_q;
		col_t next_col;
		row_t row_at_latch;
		pulses_in_row = 0;
		col_known     = 1'b0;
		row_started   = 1'b0;
		latch_q       = 1'b0;
		forever begin
			@(negedge clk);
			if (scan_check_en && display_clk) begin
				top_idx = int'(row_addr) * COLUMNS + int'(col_addr);
				check_value("dout_a", dout_a, expected_pixel(top_idx, $time - HALF_PERIOD));
				check_value("dout_b", dout_b,
					expected_pixel(top_idx + HALF_WORDS, $time - HALF_PERIOD));
				if (col_known) begin
					check_value("col_addr", col_addr, next_col);
				end
				next_col  = col_t'((int'(col_addr) + 1) % COLUMNS);
				col_known = 1'b1;
				pulses_in_row++;
			end
			if (scan_check_en && latch && !latch_q) begin
				if (row_started) begin
					check_value("display_clk pulses per row", pulses_in_row, COLUMNS);
				end
				row_at_latch  = row_addr;
				pulses_in_row = 0;
				row_started   = 1'b1;
			end
			if (scan_check_en && !latch && latch_q && row_started) begin
				check_value("row_addr", row_addr, (int'(row_at_latch) + 1) % ROWS);
			end
			latch_q = latch;
		end
	end

	initial begin
		int     idx;
		row_t   start_row;
		row_t   target_row;
		col_t   target_col;
		pixel_t new_pix;

		void'($urandom(32'h4448a3cd)); // seeds the generator
		rst           = 1'b1;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = '0;
		pwdata        = '0;
		scan_check_en = 1'b0;
		for (int i = 0; i < FB_WORDS; i++) begin
			model[i]     = '0;
			model_old[i] = '0;
			wr_time[i]   = 0;
		end

		@(negedge clk);
		check_idle_outputs(); // in reset
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_idle_outputs(); // scan not started yet

		for (int i = 0; i < FB_WORDS; i++) begin
			apb_transfer(paddr_t'(i * 4), word_t'($urandom), 1'b1, 1'b0);
		end
		wait_latch_rise();
		@(posedge clk);
		scan_check_en = 1'b1;

		// table transfers land mid-scan
		for (int i = 0; i < NUM_APB_VECS; i++) begin
			apb_transfer(APB_VECS[i].addr, APB_VECS[i].data, APB_VECS[i].write,
				APB_VECS[i].err);
		end

		// one full frame
		wait_latch_rise();
		start_row = row_addr;
		repeat (ROWS) wait_latch_rise();
		check_value("row_addr after a frame", row_addr, start_row);

		// rewrite pixels a couple of rows ahead of the scan
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			target_row = row_t'((int'(row_addr) + 2) % ROWS);
			target_col = col_t'($urandom % COLUMNS);
			idx        = (k % 2) * HALF_WORDS + int'(target_row) * COLUMNS
				+ int'(target_col);
			new_pix    = model[idx] ^ pixel_t'(1 + $urandom % 15);
			apb_transfer(paddr_t'(idx * 4), word_t'(new_pix), 1'b1, 1'b0);
			wait_shift_out(target_row, target_col);
			if (k % 2 == 0) begin
				check_value("dout_a rewritten", dout_a, new_pix);
			end else begin
				check_value("dout_b rewritten", dout_b, new_pix);
			end
		end

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
